/* hw/blit_geom_pkg.sv */
package blit_geom_pkg;

    // Width of one bus word as seen on the enqueue and dequeue data ports
    localparam int word_bits = 32;

    // Pixel counts on the strobes cover 0 to 16 pixels, which is one word
    // at the smallest depth
    localparam int count_bits = 5;

    // Fill level and free space cover 0 to 32 pixels, the deepest ring
    localparam int level_bits = 6;

    // Every lane holds this many bus words worth of its own pixels.
    // The entry count of a lane follows from it, so the rings scale together
    localparam int ring_words = 2;

endpackage

/* hw/blit_pixel_pkg.sv */
package blit_pixel_pkg;

    // Pixel depth selected by the blitter's color mode register
    typedef enum logic [1:0] {
        mode_2bpp  = 2'd0,
        mode_4bpp  = 2'd1,
        mode_8bpp  = 2'd2,
        mode_16bpp = 2'd3
    } color_mode_t;

    // One bus word seen as pixels of each supported depth.
    // The ranges ascend so that pixel 0 lands in the most significant bits,
    // which is the order the fetch unit delivers them in
    typedef union packed {
        logic [0:blit_geom_pkg::word_bits/2-1][1:0]   px2;
        logic [0:blit_geom_pkg::word_bits/4-1][3:0]   px4;
        logic [0:blit_geom_pkg::word_bits/8-1][7:0]   px8;
        logic [0:blit_geom_pkg::word_bits/16-1][15:0] px16;
    } pixel_word_t;

endpackage

/* hw/blit_pixel_lane.sv */
`timescale 1ns/1ps

module blit_pixel_lane #(
    parameter int bpp = 2
) (
    input  logic                                    CLK,
    input  logic                                    RESET_n,
    input  logic                                    CLEAR,
    input  logic                                    ENQUEUE,
    input  logic [blit_geom_pkg::count_bits-1:0]    ENQUEUE_COUNT,
    input  blit_pixel_pkg::pixel_word_t             ENQUEUE_DATA,
    input  logic                                    DEQUEUE,
    input  logic [blit_geom_pkg::count_bits-1:0]    DEQUEUE_COUNT,
    output blit_pixel_pkg::pixel_word_t             DEQUEUE_DATA
);

    localparam int cnt_w    = blit_geom_pkg::count_bits;
    localparam int ppw      = blit_geom_pkg::word_bits / bpp;
    localparam int entries  = blit_geom_pkg::ring_words * ppw;
    localparam int ptr_bits = $clog2(entries);

    // Pixel storage, one entry per pixel
    logic [bpp-1:0]      ring [entries];

    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;

    // Each pixel slot of a word sits at a fixed distance from the pointer.
    // The entry count is a power of two so the sum wraps by itself
    logic [ptr_bits-1:0] wr_slot [ppw];
    logic [ptr_bits-1:0] rd_slot [ppw];

    logic [bpp-1:0]      in_px  [ppw];
    logic [bpp-1:0]      out_px [ppw];

    blit_pixel_pkg::pixel_word_t rd_word;

    // Pick the view of the bus word that matches this lane's depth
    generate
        case (bpp)
            2: begin : g_px2
                always_comb begin
                    for (int i = 0; i < ppw; i++) begin
                        in_px[i]       = ENQUEUE_DATA.px2[i];
                        rd_word.px2[i] = out_px[i];
                    end
                end
            end
            4: begin : g_px4
                always_comb begin
                    for (int i = 0; i < ppw; i++) begin
                        in_px[i]       = ENQUEUE_DATA.px4[i];
                        rd_word.px4[i] = out_px[i];
                    end
                end
            end
            8: begin : g_px8
                always_comb begin
                    for (int i = 0; i < ppw; i++) begin
                        in_px[i]       = ENQUEUE_DATA.px8[i];
                        rd_word.px8[i] = out_px[i];
                    end
                end
            end
            default: begin : g_px16
                always_comb begin
                    for (int i = 0; i < ppw; i++) begin
                        in_px[i]        = ENQUEUE_DATA.px16[i];
                        rd_word.px16[i] = out_px[i];
                    end
                end
            end
        endcase
    endgenerate

    always_comb begin
        for (int i = 0; i < ppw; i++) begin
            wr_slot[i] = wr_ptr + ptr_bits'(i);
            rd_slot[i] = rd_ptr + ptr_bits'(i);
        end
    end

    // The whole word is read every time, the caller only uses the
    // first DEQUEUE_COUNT pixels of it
    always_comb begin
        for (int i = 0; i < ppw; i++) begin
            out_px[i] = ring[rd_slot[i]];
        end
    end

    // Only the first ENQUEUE_COUNT pixels of the word are stored
    always_ff @(posedge CLK) begin
        if (ENQUEUE && !CLEAR) begin
            for (int i = 0; i < ppw; i++) begin
                if (cnt_w'(i) < ENQUEUE_COUNT) begin
                    ring[wr_slot[i]] <= in_px[i];
                end
            end
        end
    end

    // Truncating the count to the pointer width is the modulo of the ring
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (CLEAR) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (ENQUEUE) begin
                wr_ptr <= wr_ptr + ptr_bits'(ENQUEUE_COUNT);
            end
            if (DEQUEUE) begin
                rd_ptr <= rd_ptr + ptr_bits'(DEQUEUE_COUNT);
            end
        end
    end

    // The ring write lands on the same edge, so a dequeue here sees only
    // pixels that were stored before it
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            DEQUEUE_DATA <= '0;
        end else if (DEQUEUE && !CLEAR) begin
            DEQUEUE_DATA <= rd_word;
        end
    end

endmodule

/* hw/blit_fill_counter.sv */
`timescale 1ns/1ps

module blit_fill_counter (
    input  logic                                    CLK,
    input  logic                                    RESET_n,
    input  logic                                    CLEAR,
    input  blit_pixel_pkg::color_mode_t             CLRM,
    input  logic                                    ENQUEUE,
    input  logic [blit_geom_pkg::count_bits-1:0]    ENQUEUE_COUNT,
    input  logic                                    DEQUEUE,
    input  logic [blit_geom_pkg::count_bits-1:0]    DEQUEUE_COUNT,
    output logic [blit_geom_pkg::level_bits-1:0]    AVAIL_COUNT,
    output logic [blit_geom_pkg::level_bits-1:0]    FREE_COUNT
);

    localparam int lvl_w     = blit_geom_pkg::level_bits;
    localparam int ring_bits = blit_geom_pkg::ring_words * blit_geom_pkg::word_bits;

    logic [lvl_w-1:0] enq_amount;
    logic [lvl_w-1:0] deq_amount;
    logic [lvl_w-1:0] capacity;

    // An idle strobe contributes nothing, so both can be summed every cycle
    always_comb begin
        enq_amount = ENQUEUE ? lvl_w'(ENQUEUE_COUNT) : '0;
        deq_amount = DEQUEUE ? lvl_w'(DEQUEUE_COUNT) : '0;
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            AVAIL_COUNT <= '0;
        end else if (CLEAR) begin
            AVAIL_COUNT <= '0;
        end else begin
            AVAIL_COUNT <= AVAIL_COUNT + enq_amount - deq_amount;
        end
    end

    // Capacity in pixels is the ring size in bits over the pixel depth
    always_comb begin
        case (CLRM)
            blit_pixel_pkg::mode_2bpp: begin
                capacity = lvl_w'(ring_bits / 2);
            end
            blit_pixel_pkg::mode_4bpp: begin
                capacity = lvl_w'(ring_bits / 4);
            end
            blit_pixel_pkg::mode_8bpp: begin
                capacity = lvl_w'(ring_bits / 8);
            end
            default: begin
                capacity = lvl_w'(ring_bits / 16);
            end
        endcase
    end

    // CLRM only moves together with a clear, so this never goes negative
    // while the caller respects the counts
    assign FREE_COUNT = capacity - AVAIL_COUNT;

endmodule

/* hw/blit_fifo.sv */
`timescale 1ns/1ps

module blit_fifo (
    input  logic                                    CLK,
    input  logic                                    RESET_n,

    input  blit_pixel_pkg::color_mode_t             CLRM,
    input  logic                                    CLEAR,

    input  logic                                    ENQUEUE,
    input  logic [blit_geom_pkg::count_bits-1:0]    ENQUEUE_COUNT,
    input  logic [blit_geom_pkg::word_bits-1:0]     ENQUEUE_DATA,

    input  logic                                    DEQUEUE,
    input  logic [blit_geom_pkg::count_bits-1:0]    DEQUEUE_COUNT,

    output logic [blit_geom_pkg::word_bits-1:0]     DEQUEUE_DATA2,
    output logic [blit_geom_pkg::word_bits-1:0]     DEQUEUE_DATA4,
    output logic [blit_geom_pkg::word_bits-1:0]     DEQUEUE_DATA8,
    output logic [blit_geom_pkg::word_bits-1:0]     DEQUEUE_DATA16,
    output logic [blit_geom_pkg::level_bits-1:0]    AVAIL_COUNT,
    output logic [blit_geom_pkg::level_bits-1:0]    FREE_COUNT
);

    blit_pixel_pkg::pixel_word_t enq_word;
    blit_pixel_pkg::pixel_word_t deq_word2;
    blit_pixel_pkg::pixel_word_t deq_word4;
    blit_pixel_pkg::pixel_word_t deq_word8;
    blit_pixel_pkg::pixel_word_t deq_word16;

    assign enq_word       = ENQUEUE_DATA;
    assign DEQUEUE_DATA2  = deq_word2;
    assign DEQUEUE_DATA4  = deq_word4;
    assign DEQUEUE_DATA8  = deq_word8;
    assign DEQUEUE_DATA16 = deq_word16;

    // All four lanes track the same stream, the writer picks the output
    // that matches the current color mode
    blit_pixel_lane #(.bpp(2)) lane_2 (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .CLEAR         (CLEAR),
        .ENQUEUE       (ENQUEUE),
        .ENQUEUE_COUNT (ENQUEUE_COUNT),
        .ENQUEUE_DATA  (enq_word),
        .DEQUEUE       (DEQUEUE),
        .DEQUEUE_COUNT (DEQUEUE_COUNT),
        .DEQUEUE_DATA  (deq_word2)
    );

    blit_pixel_lane #(.bpp(4)) lane_4 (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .CLEAR         (CLEAR),
        .ENQUEUE       (ENQUEUE),
        .ENQUEUE_COUNT (ENQUEUE_COUNT),
        .ENQUEUE_DATA  (enq_word),
        .DEQUEUE       (DEQUEUE),
        .DEQUEUE_COUNT (DEQUEUE_COUNT),
        .DEQUEUE_DATA  (deq_word4)
    );

    blit_pixel_lane #(.bpp(8)) lane_8 (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .CLEAR         (CLEAR),
        .ENQUEUE       (ENQUEUE),
        .ENQUEUE_COUNT (ENQUEUE_COUNT),
        .ENQUEUE_DATA  (enq_word),
        .DEQUEUE       (DEQUEUE),
        .DEQUEUE_COUNT (DEQUEUE_COUNT),
        .DEQUEUE_DATA  (deq_word8)
    );

    blit_pixel_lane #(.bpp(16)) lane_16 (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .CLEAR         (CLEAR),
        .ENQUEUE       (ENQUEUE),
        .ENQUEUE_COUNT (ENQUEUE_COUNT),
        .ENQUEUE_DATA  (enq_word),
        .DEQUEUE       (DEQUEUE),
        .DEQUEUE_COUNT (DEQUEUE_COUNT),
        .DEQUEUE_DATA  (deq_word16)
    );

    // The fill level is shared, counts are in pixels whatever the depth
    blit_fill_counter fill_counter (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .CLEAR         (CLEAR),
        .CLRM          (CLRM),
        .ENQUEUE       (ENQUEUE),
        .ENQUEUE_COUNT (ENQUEUE_COUNT),
        .DEQUEUE       (DEQUEUE),
        .DEQUEUE_COUNT (DEQUEUE_COUNT),
        .AVAIL_COUNT   (AVAIL_COUNT),
        .FREE_COUNT    (FREE_COUNT)
    );

endmodule

/* verif/blit_fifo_vectors.svh */
`ifndef BLIT_FIFO_VECTORS_SVH
`define BLIT_FIFO_VECTORS_SVH

// Each row holds clear, mode, enqueue, enqueue count, enqueue data, random,
// dequeue, dequeue count, expected avail, expected free and expected word
typedef struct packed {
    logic        clr;
    logic [1:0]  mode;
    logic        enq;
    logic [4:0]  enq_cnt;
    logic [31:0] enq_data;
    logic        rnd;
    logic        deq;
    logic [4:0]  deq_cnt;
    logic [5:0]  exp_avail;
    logic [5:0]  exp_free;
    logic [31:0] exp_word;
} vector_t;

localparam int num_vectors = 28;

// Rows marked random get fresh data and take their expected word from the model
vector_t vectors [num_vectors] = '{
    // Three enqueues in 2 bpp after reset fill the ring and wrap the write pointer
    '{1'b0, 2'd0, 1'b0, 5'd0, 32'h0000_0000, 1'b0, 1'b0, 5'd0, 6'd0, 6'd32, 32'h0000_0000},
    '{1'b0, 2'd0, 1'b1, 5'd5, 32'hE4E4_E4E4, 1'b0, 1'b0, 5'd0, 6'd5, 6'd27, 32'h0000_0000},
    '{1'b0, 2'd0, 1'b1, 5'd16, 32'h0123_4567, 1'b0, 1'b0, 5'd0, 6'd21, 6'd11, 32'h0000_0000},
    '{1'b0, 2'd0, 1'b1, 5'd11, 32'hFEDC_BA98, 1'b0, 1'b0, 5'd0, 6'd32, 6'd0, 32'h0000_0000},
    '{1'b0, 2'd0, 1'b0, 5'd0, 32'h0000_0000, 1'b0, 1'b1, 5'd16, 6'd16, 6'd16, 32'hE4C0_48D1},
    '{1'b0, 2'd0, 1'b0, 5'd0, 32'h0000_0000, 1'b0, 1'b1, 5'd16, 6'd0, 6'd32, 32'h59FF_B72E},
    // In 8 bpp the bytes come back in order on DEQUEUE_DATA8
    '{1'b1, 2'd2, 1'b0, 5'd0, 32'h0000_0000, 1'b0, 1'b0, 5'd0, 6'd0, 6'd8, 32'h0000_0000},
    '{1'b0, 2'd2, 1'b1, 5'd3, 32'h1122_3344, 1'b0, 1'b0, 5'd0, 6'd3, 6'd5, 32'h0000_0000},
    '{1'b0, 2'd2, 1'b1, 5'd4, 32'hA1B2_C3D4, 1'b0, 1'b0, 5'd0, 6'd7, 6'd1, 32'h0000_0000},
    '{1'b0, 2'd2, 1'b1, 5'd1, 32'h5566_7788, 1'b0, 1'b0, 5'd0, 6'd8, 6'd0, 32'h0000_0000},
    '{1'b0, 2'd2, 1'b0, 5'd0, 32'h0000_0000, 1'b0, 1'b1, 5'd4, 6'd4, 6'd4, 32'h1122_33A1},
    '{1'b0, 2'd2, 1'b0, 5'd0, 32'h0000_0000, 1'b0, 1'b1, 5'd4, 6'd0, 6'd8, 32'hB2C3_D455},
    // 4 bpp with enqueue and dequeue on the same edge
    '{1'b1, 2'd1, 1'b0, 5'd0, 32'h0000_0000, 1'b0, 1'b0, 5'd0, 6'd0, 6'd16, 32'h0000_0000},
    '{1'b0, 2'd1, 1'b1, 5'd6, 32'h1234_5678, 1'b0, 1'b0, 5'd0, 6'd6, 6'd10, 32'h0000_0000},
    '{1'b0, 2'd1, 1'b1, 5'd8, 32'h9ABC_DEF0, 1'b0, 1'b1, 5'd6, 6'd8, 6'd8, 32'h1234_5600},
    '{1'b0, 2'd1, 1'b0, 5'd0, 32'h0000_0000, 1'b0, 1'b1, 5'd8, 6'd0, 6'd16, 32'h9ABC_DEF0},
    // Random words in 16 bpp run round the four entry ring several times
    '{1'b1, 2'd3, 1'b0, 5'd0, 32'h0000_0000, 1'b0, 1'b0, 5'd0, 6'd0, 6'd4, 32'h0000_0000},
    '{1'b0, 2'd3, 1'b1, 5'd2, 32'h0000_0000, 1'b1, 1'b0, 5'd0, 6'd2, 6'd2, 32'h0000_0000},
    '{1'b0, 2'd3, 1'b1, 5'd2, 32'h0000_0000, 1'b1, 1'b1, 5'd2, 6'd2, 6'd2, 32'h0000_0000},
    '{1'b0, 2'd3, 1'b1, 5'd2, 32'h0000_0000, 1'b1, 1'b1, 5'd2, 6'd2, 6'd2, 32'h0000_0000},
    '{1'b0, 2'd3, 1'b1, 5'd2, 32'h0000_0000, 1'b1, 1'b1, 5'd2, 6'd2, 6'd2, 32'h0000_0000},
    '{1'b0, 2'd3, 1'b1, 5'd2, 32'h0000_0000, 1'b1, 1'b1, 5'd2, 6'd2, 6'd2, 32'h0000_0000},
    '{1'b0, 2'd3, 1'b1, 5'd2, 32'h0000_0000, 1'b1, 1'b0, 5'd0, 6'd4, 6'd0, 32'h0000_0000},
    '{1'b0, 2'd3, 1'b0, 5'd0, 32'h0000_0000, 1'b1, 1'b1, 5'd2, 6'd2, 6'd2, 32'h0000_0000},
    '{1'b0, 2'd3, 1'b0, 5'd0, 32'h0000_0000, 1'b1, 1'b1, 5'd1, 6'd1, 6'd3, 32'h0000_0000},
    // Clear wins over a same cycle enqueue and drops the pixel still queued
    // The next word then starts again at slot 0
    '{1'b1, 2'd3, 1'b1, 5'd2, 32'hDEAD_BEEF, 1'b0, 1'b0, 5'd0, 6'd0, 6'd4, 32'h0000_0000},
    '{1'b0, 2'd3, 1'b1, 5'd2, 32'h1357_2468, 1'b0, 1'b0, 5'd0, 6'd2, 6'd2, 32'h0000_0000},
    '{1'b0, 2'd3, 1'b0, 5'd0, 32'h0000_0000, 1'b0, 1'b1, 5'd2, 6'd0, 6'd4, 32'h1357_2468}
};

`endif

/* verif/blit_fifo_tb.sv */
`timescale 1ns/1ps

module blit_fifo_tb;

    `include "blit_fifo_vectors.svh"

    localparam int reset_cycles = 10;
    // Each row takes one drive cycle and one idle cycle
    localparam int cycle_limit  = 2 * num_vectors + reset_cycles + 50;

    logic                        CLK;
    logic                        RESET_n;
    blit_pixel_pkg::color_mode_t clrm;
    logic                        clear;
    logic                        enqueue;
    logic [4:0]                  enqueue_count;
    logic [31:0]                 enqueue_data;
    logic                        dequeue;
    logic [4:0]                  dequeue_count;
    logic [31:0]                 dequeue_data2;
    logic [31:0]                 dequeue_data4;
    logic [31:0]                 dequeue_data8;
    logic [31:0]                 dequeue_data16;
    logic [5:0]                  avail_count;
    logic [5:0]                  free_count;

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    // Reference queue of pixels in the mode of the current rows
    int unsigned model_q [$];

    blit_fifo blit_fifo_i (
        .CLK            (CLK),
        .RESET_n        (RESET_n),
        .CLRM           (clrm),
        .CLEAR          (clear),
        .ENQUEUE        (enqueue),
        .ENQUEUE_COUNT  (enqueue_count),
        .ENQUEUE_DATA   (enqueue_data),
        .DEQUEUE        (dequeue),
        .DEQUEUE_COUNT  (dequeue_count),
        .DEQUEUE_DATA2  (dequeue_data2),
        .DEQUEUE_DATA4  (dequeue_data4),
        .DEQUEUE_DATA8  (dequeue_data8),
        .DEQUEUE_DATA16 (dequeue_data16),
        .AVAIL_COUNT    (avail_count),
        .FREE_COUNT     (free_count)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic int depth_of(input logic [1:0] mode);
        return 2 << mode;
    endfunction

    // Pixel 0 sits in the most significant bits of the word
    function automatic int unsigned pixel_of(input logic [31:0] w, input int i, input int bpp);
        return (w >> (32 - (i + 1) * bpp)) & ((1 << bpp) - 1);
    endfunction

    function automatic logic [31:0] word_mask(input int count, input int bpp);
        return ~(32'hFFFF_FFFF >> (count * bpp));
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // A dequeue sees the queue as it stood before the same edge's enqueue
    task automatic update_model(input vector_t row, input logic [31:0] data,
                                output logic [31:0] deq_word);
        int bpp;
        int unsigned px;
        bpp = depth_of(row.mode);
        deq_word = '0;
        if (row.clr) begin
            model_q.delete();
        end else begin
            if (row.deq) begin
                for (int i = 0; i < int'(row.deq_cnt); i++) begin
                    if (model_q.size() > 0) begin
                        px = model_q.pop_front();
                        deq_word = deq_word | (32'(px) << (32 - (i + 1) * bpp));
                    end
                end
            end
            if (row.enq) begin
                for (int i = 0; i < int'(row.enq_cnt); i++) begin
                    model_q.push_back(pixel_of(data, i, bpp));
                end
            end
        end
    endtask

    initial begin
        vector_t     row;
        logic [31:0] data;
        logic [31:0] model_word;
        logic [31:0] exp_word;
        logic [31:0] got_word;
        logic [31:0] mask;
        int          errors_before;
        void'($urandom(32551));
        RESET_n       = 1'b0;
        clrm          = blit_pixel_pkg::mode_2bpp;
        clear         = 1'b0;
        enqueue       = 1'b0;
        enqueue_count = '0;
        enqueue_data  = '0;
        dequeue       = 1'b0;
        dequeue_count = '0;
        repeat (reset_cycles) @(posedge CLK);
        RESET_n <= 1'b1;

        for (int r = 0; r < num_vectors; r++) begin
            row  = vectors[r];
            data = row.rnd ? $urandom : row.enq_data;
            @(posedge CLK);
            clear         <= row.clr;
            clrm          <= blit_pixel_pkg::color_mode_t'(row.mode);
            enqueue       <= row.enq;
            enqueue_count <= row.enq_cnt;
            enqueue_data  <= data;
            dequeue       <= row.deq;
            dequeue_count <= row.deq_cnt;
            update_model(row, data, model_word);
            @(posedge CLK);
            clear   <= 1'b0;
            enqueue <= 1'b0;
            dequeue <= 1'b0;
            @(negedge CLK);

            errors_before = errors;
            check_value("AVAIL_COUNT", 32'(avail_count), 32'(row.exp_avail));
            check_value("FREE_COUNT", 32'(free_count), 32'(row.exp_free));
            // No dequeue has happened yet, so every output still holds its reset value
            if (r == 0) begin
                check_value("DEQUEUE_DATA2 after reset", dequeue_data2, '0);
                check_value("DEQUEUE_DATA4 after reset", dequeue_data4, '0);
                check_value("DEQUEUE_DATA8 after reset", dequeue_data8, '0);
                check_value("DEQUEUE_DATA16 after reset", dequeue_data16, '0);
            end
            if (row.deq && !row.clr) begin
                case (row.mode)
                    2'd0: got_word = dequeue_data2;
                    2'd1: got_word = dequeue_data4;
                    2'd2: got_word = dequeue_data8;
                    default: got_word = dequeue_data16;
                endcase
                exp_word = row.rnd ? model_word : row.exp_word;
                mask     = word_mask(int'(row.deq_cnt), depth_of(row.mode));
                check_value("DEQUEUE_DATA", got_word & mask, exp_word & mask);
            end
            if (errors == errors_before) begin
                $display("Test %0d: ok", r);
            end else begin
                $display("Test %0d: mismatch", r);
            end
        end

        $display("Tests run: %0d, checks: %0d, errors: %0d", num_vectors, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+verif
hw/blit_geom_pkg.sv
hw/blit_pixel_pkg.sv
hw/blit_pixel_lane.sv
hw/blit_fill_counter.sv
hw/blit_fifo.sv
verif/blit_fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the pixel queue testbench with Verilator and run it.
# Exit status is 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module blit_fifo_tb \
    -f src.f \
    --Mdir obj_dir -o blit_fifo_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed with status $status"
    exit 1
fi

./obj_dir/blit_fifo_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$SIM_LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi
